// File: alu.sv
`timescale 1ns/1ns

module alu (
    decode_bus_if.alu_side               bus,
    output logic [cpu_cfg_pkg::xlen-1:0] alu_result
);
    import cpu_cfg_pkg::*;
    import cpu_isa_pkg::*;

    alu_op_t         op;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [4:0]      shamt;
    logic            lt_s;
    logic            lt_u;
    logic [xlen-1:0] sra_res;

    assign op    = bus.alu_op;
    assign src1  = bus.alu_src1;
    assign src2  = bus.alu_src2;
    assign shamt = src2[4:0];

    assign lt_s    = $signed(src1) < $signed(src2);
    assign lt_u    = src1 < src2;
    assign sra_res = $signed(src1) >>> shamt;

    // one-hot op, so the terms just or together
    assign alu_result = ({xlen{op[alu_add]}}  & (src1 + src2))
                      | ({xlen{op[alu_sub]}}  & (src1 - src2))
                      | ({xlen{op[alu_slt]}}  & {{(xlen-1){1'b0}}, lt_s})
                      | ({xlen{op[alu_sltu]}} & {{(xlen-1){1'b0}}, lt_u})
                      | ({xlen{op[alu_and]}}  & (src1 & src2))
                      | ({xlen{op[alu_nor]}}  & ~(src1 | src2))
                      | ({xlen{op[alu_or]}}   & (src1 | src2))
                      | ({xlen{op[alu_xor]}}  & (src1 ^ src2))
                      | ({xlen{op[alu_sll]}}  & (src1 << shamt))
                      | ({xlen{op[alu_srl]}}  & (src1 >> shamt))
                      | ({xlen{op[alu_sra]}}  & sra_res)
                      | ({xlen{op[alu_lui]}}  & src2);   // si20 already shifted

endmodule

// File: compile.f
cpu_cfg_pkg.sv
cpu_isa_pkg.sv
decode_bus_if.sv
stage_sequencer.sv
fetch_unit.sv
inst_decoder.sv
regfile.sv
alu.sv
mem_wb_unit.sv
mycpu_top.sv
tb_mycpu.sv

// File: cpu_cfg_pkg.sv
package cpu_cfg_pkg;

    localparam int xlen      = 32;
    localparam int reg_count = 32;
    localparam int reg_aw    = $clog2(reg_count);

    localparam logic [xlen-1:0] reset_pc = 32'h1c00_0000;

    // one instruction walks a subset of these
    typedef enum logic [2:0] {
        st_if  = 3'd0,
        st_id  = 3'd1,
        st_exe = 3'd2,
        st_mem = 3'd3,
        st_wb  = 3'd4
    } stage_t;

endpackage

// File: cpu_isa_pkg.sv
package cpu_isa_pkg;

    // inst[31:26]
    localparam logic [5:0] op6_base  = 6'h00;
    localparam logic [5:0] op6_lu12i = 6'h05;
    localparam logic [5:0] op6_mem   = 6'h0a;
    localparam logic [5:0] op6_jirl  = 6'h13;
    localparam logic [5:0] op6_b     = 6'h14;
    localparam logic [5:0] op6_bl    = 6'h15;
    localparam logic [5:0] op6_beq   = 6'h16;
    localparam logic [5:0] op6_bne   = 6'h17;

    // inst[25:22]
    localparam logic [3:0] op4_reg   = 4'h0;
    localparam logic [3:0] op4_shift = 4'h1;
    localparam logic [3:0] op4_ld_w  = 4'h2;
    localparam logic [3:0] op4_st_w  = 4'h6;
    localparam logic [3:0] op4_addi  = 4'ha;

    // inst[21:20]
    localparam logic [1:0] op2_shift = 2'h0;
    localparam logic [1:0] op2_reg   = 2'h1;

    // inst[19:15]
    localparam logic [4:0] op5_add  = 5'h00;
    localparam logic [4:0] op5_slli = 5'h01;
    localparam logic [4:0] op5_sub  = 5'h02;
    localparam logic [4:0] op5_slt  = 5'h04;
    localparam logic [4:0] op5_sltu = 5'h05;
    localparam logic [4:0] op5_nor  = 5'h08;
    localparam logic [4:0] op5_and  = 5'h09;
    localparam logic [4:0] op5_srli = 5'h09;  // shift group, not the and
    localparam logic [4:0] op5_or   = 5'h0a;
    localparam logic [4:0] op5_xor  = 5'h0b;
    localparam logic [4:0] op5_srai = 5'h11;

    // bit positions in the one-hot alu op
    localparam int alu_add  = 0;
    localparam int alu_sub  = 1;
    localparam int alu_slt  = 2;
    localparam int alu_sltu = 3;
    localparam int alu_and  = 4;
    localparam int alu_nor  = 5;
    localparam int alu_or   = 6;
    localparam int alu_xor  = 7;
    localparam int alu_sll  = 8;
    localparam int alu_srl  = 9;
    localparam int alu_sra  = 10;
    localparam int alu_lui  = 11;

    typedef logic [11:0] alu_op_t;

    typedef struct packed {
        logic gr_we;
        logic mem_we;
        logic res_from_mem;
        logic is_load;
        logic is_store;
        logic is_cond_only;   // b, beq, bne
        logic src1_is_pc;
        logic src2_is_imm;
        logic src_reg_is_rd;
    } ctrl_t;

endpackage

// File: decode_bus_if.sv
`timescale 1ns/1ns

interface decode_bus_if;
    import cpu_cfg_pkg::*;
    import cpu_isa_pkg::*;

    alu_op_t           alu_op;
    logic [xlen-1:0]   alu_src1;
    logic [xlen-1:0]   alu_src2;
    logic [xlen-1:0]   rkd_value;   // store data
    logic [reg_aw-1:0] dest;
    ctrl_t             ctrl;

    modport producer (output alu_op, alu_src1, alu_src2, rkd_value, dest, ctrl);
    modport alu_side (input alu_op, alu_src1, alu_src2);
    modport wb_side  (input ctrl, dest, rkd_value);
    modport seq_side (input ctrl);

endinterface

// File: fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
    input  logic                         clk,
    input  logic                         reset,
    input  cpu_cfg_pkg::stage_t          stage,
    input  logic                         br_taken,
    input  logic [cpu_cfg_pkg::xlen-1:0] br_target,
    output logic [cpu_cfg_pkg::xlen-1:0] inst_sram_addr,
    input  logic [cpu_cfg_pkg::xlen-1:0] inst_sram_rdata,
    output logic [cpu_cfg_pkg::xlen-1:0] inst,
    output logic [cpu_cfg_pkg::xlen-1:0] pc
);
    import cpu_cfg_pkg::*;

    logic [xlen-1:0] inst_q;

    // pc holds through ID so the sram output stays valid there
    assign inst_sram_addr = pc;

    // fresh word in ID, held copy afterwards
    assign inst = (stage == st_id) ? inst_sram_rdata : inst_q;

    always_ff @(posedge clk) begin
        if (stage == st_id) begin
            inst_q <= inst_sram_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (stage == st_id) begin
            pc <= br_taken ? br_target : pc + 32'd4;
        end
    end

endmodule

// File: inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder (
    input  logic                           clk,
    input  logic                           reset,
    input  cpu_cfg_pkg::stage_t            stage,
    input  logic [cpu_cfg_pkg::xlen-1:0]   inst,
    input  logic [cpu_cfg_pkg::xlen-1:0]   pc,
    output logic [cpu_cfg_pkg::reg_aw-1:0] rf_raddr1,
    output logic [cpu_cfg_pkg::reg_aw-1:0] rf_raddr2,
    input  logic [cpu_cfg_pkg::xlen-1:0]   rf_rdata1,
    input  logic [cpu_cfg_pkg::xlen-1:0]   rf_rdata2,
    output logic                           br_taken,
    output logic [cpu_cfg_pkg::xlen-1:0]   br_target,
    output logic [cpu_cfg_pkg::xlen-1:0]   retire_pc,
    decode_bus_if.producer                 bus
);
    import cpu_cfg_pkg::*;
    import cpu_isa_pkg::*;

    logic [5:0]        op6;
    logic [3:0]        op4;
    logic [1:0]        op2;
    logic [4:0]        op5;
    logic [reg_aw-1:0] rd;
    logic [reg_aw-1:0] rj;
    logic [reg_aw-1:0] rk;
    logic [xlen-1:0]   si12;
    logic [xlen-1:0]   ui5;
    logic [xlen-1:0]   si16;
    logic [xlen-1:0]   si20;
    logic [xlen-1:0]   si26;
    logic [xlen-1:0]   imm;
    logic [xlen-1:0]   br_offs;
    alu_op_t           alu_op_d;
    ctrl_t             ctrl_d;
    ctrl_t             ctrl_q;

    assign op6 = inst[31:26];
    assign op4 = inst[25:22];
    assign op2 = inst[21:20];
    assign op5 = inst[19:15];
    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];

    assign si12 = {{20{inst[21]}}, inst[21:10]};
    assign ui5  = {27'd0, inst[14:10]};
    assign si16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign si20 = {inst[24:5], 12'd0};
    assign si26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

    always_comb begin
        alu_op_d = '0;
        ctrl_d   = '0;
        imm      = si12;
        case (op6)
            op6_base: begin
                if (op4 == op4_reg && op2 == op2_reg) begin
                    ctrl_d.gr_we = 1'b1;
                    case (op5)
                        op5_add:  alu_op_d[alu_add]  = 1'b1;
                        op5_sub:  alu_op_d[alu_sub]  = 1'b1;
                        op5_slt:  alu_op_d[alu_slt]  = 1'b1;
                        op5_sltu: alu_op_d[alu_sltu] = 1'b1;
                        op5_nor:  alu_op_d[alu_nor]  = 1'b1;
                        op5_and:  alu_op_d[alu_and]  = 1'b1;
                        op5_or:   alu_op_d[alu_or]   = 1'b1;
                        op5_xor:  alu_op_d[alu_xor]  = 1'b1;
                        default:  ctrl_d.gr_we = 1'b0;
                    endcase
                end else if (op4 == op4_shift && op2 == op2_shift) begin
                    ctrl_d.gr_we       = 1'b1;
                    ctrl_d.src2_is_imm = 1'b1;
                    imm                = ui5;
                    case (op5)
                        op5_slli: alu_op_d[alu_sll] = 1'b1;
                        op5_srli: alu_op_d[alu_srl] = 1'b1;
                        op5_srai: alu_op_d[alu_sra] = 1'b1;
                        default:  ctrl_d.gr_we = 1'b0;
                    endcase
                end else if (op4 == op4_addi) begin
                    ctrl_d.gr_we       = 1'b1;
                    ctrl_d.src2_is_imm = 1'b1;
                    alu_op_d[alu_add]  = 1'b1;
                end
            end
            op6_lu12i: begin
                if (!inst[25]) begin
                    ctrl_d.gr_we       = 1'b1;
                    ctrl_d.src2_is_imm = 1'b1;
                    imm                = si20;
                    alu_op_d[alu_lui]  = 1'b1;
                end
            end
            op6_mem: begin
                ctrl_d.src2_is_imm = 1'b1;
                alu_op_d[alu_add]  = 1'b1;   // rj + si12
                if (op4 == op4_ld_w) begin
                    ctrl_d.gr_we        = 1'b1;
                    ctrl_d.res_from_mem = 1'b1;
                    ctrl_d.is_load      = 1'b1;
                end else if (op4 == op4_st_w) begin
                    ctrl_d.mem_we        = 1'b1;
                    ctrl_d.is_store      = 1'b1;
                    ctrl_d.src_reg_is_rd = 1'b1;
                end
            end
            op6_jirl, op6_bl: begin
                // link value pc + 4 goes through the alu
                ctrl_d.gr_we       = 1'b1;
                ctrl_d.src1_is_pc  = 1'b1;
                ctrl_d.src2_is_imm = 1'b1;
                imm                = xlen'(4);
                alu_op_d[alu_add]  = 1'b1;
            end
            op6_b: ctrl_d.is_cond_only = 1'b1;
            op6_beq, op6_bne: begin
                ctrl_d.is_cond_only  = 1'b1;
                ctrl_d.src_reg_is_rd = 1'b1;
            end
            default: ;
        endcase
    end

    assign rf_raddr1 = rj;
    assign rf_raddr2 = ctrl_d.src_reg_is_rd ? rd : rk;

    // resolved in ID, pc takes it at the end of the state
    assign br_offs   = (op6 == op6_b || op6 == op6_bl) ? si26 : si16;
    assign br_taken  = (op6 == op6_beq && rf_rdata1 == rf_rdata2)
                    || (op6 == op6_bne && rf_rdata1 != rf_rdata2)
                    || op6 == op6_b || op6 == op6_bl || op6 == op6_jirl;
    assign br_target = (op6 == op6_jirl) ? rf_rdata1 + si16 : pc + br_offs;

    // live decode in ID lets the sequencer skip EXE for branches
    assign bus.ctrl = (stage == st_id) ? ctrl_d : ctrl_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl_q <= '0;
        end else if (stage == st_id) begin
            ctrl_q <= ctrl_d;
        end
    end

    always_ff @(posedge clk) begin
        if (stage == st_id) begin
            bus.alu_op    <= alu_op_d;
            bus.alu_src1  <= ctrl_d.src1_is_pc ? pc : rf_rdata1;
            bus.alu_src2  <= ctrl_d.src2_is_imm ? imm : rf_rdata2;
            bus.rkd_value <= rf_rdata2;
            bus.dest      <= (op6 == op6_bl) ? reg_aw'(1) : rd;
            retire_pc     <= pc;   // pc moves on at the end of ID
        end
    end

endmodule

// File: mem_wb_unit.sv
`timescale 1ns/1ns

module mem_wb_unit (
    input  logic                           clk,
    input  logic                           reset,
    input  cpu_cfg_pkg::stage_t            stage,
    decode_bus_if.wb_side                  bus,
    input  logic [cpu_cfg_pkg::xlen-1:0]   alu_result,
    input  logic [cpu_cfg_pkg::xlen-1:0]   retire_pc,
    output logic                           data_sram_we,
    output logic [cpu_cfg_pkg::xlen-1:0]   data_sram_addr,
    output logic [cpu_cfg_pkg::xlen-1:0]   data_sram_wdata,
    input  logic [cpu_cfg_pkg::xlen-1:0]   data_sram_rdata,
    output logic                           rf_we,
    output logic [cpu_cfg_pkg::reg_aw-1:0] rf_waddr,
    output logic [cpu_cfg_pkg::xlen-1:0]   rf_wdata,
    output logic [cpu_cfg_pkg::xlen-1:0]   debug_wb_pc,
    output logic [3:0]                     debug_wb_rf_we,
    output logic [cpu_cfg_pkg::reg_aw-1:0] debug_wb_rf_wnum,
    output logic [cpu_cfg_pkg::xlen-1:0]   debug_wb_rf_wdata
);
    import cpu_cfg_pkg::*;

    logic [xlen-1:0] mem_q;

    // address goes out in EXE, load data comes back in MEM
    assign data_sram_we    = (stage == st_exe) && bus.ctrl.mem_we;
    assign data_sram_addr  = alu_result;
    assign data_sram_wdata = bus.rkd_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_q <= '0;
        end else if (stage == st_mem) begin
            mem_q <= data_sram_rdata;
        end
    end

    assign rf_we    = (stage == st_wb) && bus.ctrl.gr_we;
    assign rf_waddr = bus.dest;
    assign rf_wdata = bus.ctrl.res_from_mem ? mem_q : alu_result;

    // r0 writes show up here even though the regfile drops them
    assign debug_wb_pc       = retire_pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

// File: mycpu_top.sv
`timescale 1ns/1ns

module mycpu_top (
    input  logic        clk,
    input  logic        reset,
    // instruction sram
    output logic        inst_sram_we,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    // data sram
    output logic        data_sram_we,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    // trace
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    import cpu_cfg_pkg::*;

    stage_t            stage;
    logic [xlen-1:0]   inst;
    logic [xlen-1:0]   pc;
    logic [xlen-1:0]   retire_pc;
    logic              br_taken;
    logic [xlen-1:0]   br_target;
    logic [xlen-1:0]   alu_result;
    logic [reg_aw-1:0] rf_raddr1;
    logic [reg_aw-1:0] rf_raddr2;
    logic [xlen-1:0]   rf_rdata1;
    logic [xlen-1:0]   rf_rdata2;
    logic              rf_we;
    logic [reg_aw-1:0] rf_waddr;
    logic [xlen-1:0]   rf_wdata;

    decode_bus_if dbus ();

    // instruction memory is read-only for the core
    assign inst_sram_we    = 1'b0;
    assign inst_sram_wdata = '0;

    stage_sequencer u_seq (
        .clk(clk), .reset(reset), .bus(dbus.seq_side), .stage(stage)
    );

    fetch_unit u_fetch (
        .clk(clk), .reset(reset), .stage(stage),
        .br_taken(br_taken), .br_target(br_target),
        .inst_sram_addr(inst_sram_addr), .inst_sram_rdata(inst_sram_rdata),
        .inst(inst), .pc(pc)
    );

    inst_decoder u_dec (
        .clk(clk), .reset(reset), .stage(stage), .inst(inst), .pc(pc),
        .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .br_taken(br_taken), .br_target(br_target),
        .retire_pc(retire_pc), .bus(dbus.producer)
    );

    regfile u_regfile (
        .clk(clk),
        .raddr1(rf_raddr1), .raddr2(rf_raddr2),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    alu u_alu (
        .bus(dbus.alu_side), .alu_result(alu_result)
    );

    mem_wb_unit u_mem_wb (
        .clk(clk), .reset(reset), .stage(stage), .bus(dbus.wb_side),
        .alu_result(alu_result), .retire_pc(retire_pc),
        .data_sram_we(data_sram_we), .data_sram_addr(data_sram_addr),
        .data_sram_wdata(data_sram_wdata), .data_sram_rdata(data_sram_rdata),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

endmodule

// File: regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic                           clk,
    input  logic [cpu_cfg_pkg::reg_aw-1:0] raddr1,
    input  logic [cpu_cfg_pkg::reg_aw-1:0] raddr2,
    output logic [cpu_cfg_pkg::xlen-1:0]   rdata1,
    output logic [cpu_cfg_pkg::xlen-1:0]   rdata2,
    input  logic                           we,
    input  logic [cpu_cfg_pkg::reg_aw-1:0] waddr,
    input  logic [cpu_cfg_pkg::xlen-1:0]   wdata
);
    import cpu_cfg_pkg::*;

    logic [xlen-1:0] regs [reg_count];

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin   // r0 stays zero
            regs[waddr] <= wdata;
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module tb_mycpu --Mdir obj_dir
./obj_dir/Vtb_mycpu | tee sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "simulation did not finish"
    exit 1
fi
echo "simulation passed"

// File: stage_sequencer.sv
`timescale 1ns/1ns

module stage_sequencer (
    input  logic                clk,
    input  logic                reset,
    decode_bus_if.seq_side      bus,
    output cpu_cfg_pkg::stage_t stage
);
    import cpu_cfg_pkg::*;

    stage_t next_stage;

    always_comb begin
        case (stage)
            st_if:   next_stage = st_id;
            st_id:   next_stage = bus.ctrl.is_cond_only ? st_if : st_exe;
            st_exe: begin
                if (bus.ctrl.is_load || bus.ctrl.is_store) begin
                    next_stage = st_mem;
                end else begin
                    next_stage = st_wb;
                end
            end
            st_mem:  next_stage = bus.ctrl.is_load ? st_wb : st_if;  // stores end here
            st_wb:   next_stage = st_if;
            default: next_stage = st_if;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= st_if;
        end else begin
            stage <= next_stage;
        end
    end

endmodule

// File: tb_mycpu.sv
`timescale 1ns/1ns

module tb_mycpu;
    import cpu_cfg_pkg::*;
    import cpu_isa_pkg::*;

    typedef struct packed {
        logic [1:0]  kind;   // 1 register write, 2 store
        logic [31:0] pc;
        logic [4:0]  num;
        logic [31:0] addr;
        logic [31:0] data;
    } event_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        inst_sram_we;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata;
    logic        data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] ref_regs [32];
    logic [31:0] ref_mem [256];
    logic [31:0] ref_pc;
    logic [7:0]  prog_len;
    event_t      exp_q [$];
    int          seen = 0;
    int          n_exp = 0;
    int          n_steps = 0;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          err_value = 0;
    int          err_other = 0;

    mycpu_top mycpu_top_i (
        .clk(clk), .reset(reset),
        .inst_sram_we(inst_sram_we), .inst_sram_addr(inst_sram_addr),
        .inst_sram_wdata(inst_sram_wdata), .inst_sram_rdata(inst_sram_rdata),
        .data_sram_we(data_sram_we), .data_sram_addr(data_sram_addr),
        .data_sram_wdata(data_sram_wdata), .data_sram_rdata(data_sram_rdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_we(debug_wb_rf_we),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    always #5 clk = ~clk;

    // both srams answer one cycle after the address
    always @(posedge clk) begin
        inst_sram_rdata <= imem[inst_sram_addr[9:2]];
        data_sram_rdata <= dmem[data_sram_addr[9:2]];
        if (data_sram_we) begin
            dmem[data_sram_addr[9:2]] <= data_sram_wdata;
        end
    end

    function automatic int unsigned rnd(input int unsigned n);
        return $urandom % n;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic logic [31:0] rrr_inst(input logic [4:0] op5, input logic [4:0] rd,
                                             input logic [4:0] rj, input logic [4:0] rk);
        return {op6_base, op4_reg, op2_reg, op5, rk, rj, rd};
    endfunction

    function automatic logic [31:0] shift_inst(input logic [4:0] op5, input logic [4:0] rd,
                                               input logic [4:0] rj, input logic [4:0] ui5);
        return {op6_base, op4_shift, op2_shift, op5, ui5, rj, rd};
    endfunction

    function automatic logic [31:0] ri12_inst(input logic [5:0] op6, input logic [3:0] op4,
                                              input logic [4:0] rd, input logic [4:0] rj,
                                              input logic [11:0] si12);
        return {op6, op4, si12, rj, rd};
    endfunction

    function automatic logic [31:0] lu12i_inst(input logic [4:0] rd, input logic [19:0] si20);
        return {op6_lu12i, 1'b0, si20, rd};
    endfunction

    // beq and bne compare rj with rd, offsets count words
    function automatic logic [31:0] br16_inst(input logic [5:0] op6, input logic [4:0] rd,
                                              input logic [4:0] rj, input logic [15:0] offs);
        return {op6, offs, rj, rd};
    endfunction

    function automatic logic [31:0] br26_inst(input logic [5:0] op6, input logic [25:0] offs);
        return {op6, offs[15:0], offs[25:16]};
    endfunction

    function automatic logic [31:0] rand_alu_inst();
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] rk;
        logic [31:0] w;
        rd = 5'(2 + rnd(14));
        rj = 5'(rnd(16));
        rk = 5'(rnd(16));
        case (rnd(13))
            0:       w = rrr_inst(op5_add, rd, rj, rk);
            1:       w = rrr_inst(op5_sub, rd, rj, rk);
            2:       w = rrr_inst(op5_slt, rd, rj, rk);
            3:       w = rrr_inst(op5_sltu, rd, rj, rk);
            4:       w = rrr_inst(op5_nor, rd, rj, rk);
            5:       w = rrr_inst(op5_and, rd, rj, rk);
            6:       w = rrr_inst(op5_or, rd, rj, rk);
            7:       w = rrr_inst(op5_xor, rd, rj, rk);
            8:       w = shift_inst(op5_slli, rd, rj, 5'(rnd(32)));
            9:       w = shift_inst(op5_srli, rd, rj, 5'(rnd(32)));
            10:      w = shift_inst(op5_srai, rd, rj, 5'(rnd(32)));
            11:      w = ri12_inst(op6_base, op4_addi, rd, rj, 12'($urandom));
            default: w = lu12i_inst(rd, 20'($urandom));
        endcase
        return w;
    endfunction

    task automatic emit(input logic [31:0] w);
        imem[prog_len] = w;
        prog_len = prog_len + 8'd1;
    endtask

    task automatic build_program();
        logic [11:0] offs [$];
        logic [31:0] mark;
        mark = ri12_inst(op6_base, op4_addi, 5'd22, 5'd22, 12'd1);
        prog_len = 8'd0;
        for (int i = 0; i < 256; i++) begin
            imem[8'(i)] = br26_inst(op6_b, 26'd0);
        end
        for (int i = 2; i < 10; i++) begin   // random start values
            emit(lu12i_inst(5'(i), 20'($urandom)));
            emit(ri12_inst(op6_base, op4_addi, 5'(i), 5'(i), 12'($urandom)));
        end
        for (int i = 0; i < 24; i++) begin
            emit(rand_alu_inst());
        end
        emit(rrr_inst(op5_add, 5'd0, 5'd2, 5'd3));   // traced, but dropped
        emit(rrr_inst(op5_add, 5'd4, 5'd0, 5'd0));
        emit(rrr_inst(op5_or, 5'd5, 5'd0, 5'd2));
        for (int k = 0; k < 6; k++) begin
            offs.push_back(12'(4 * rnd(256)));
            emit(ri12_inst(op6_mem, op4_st_w, 5'(2 + k), 5'd0, offs[k]));
        end
        for (int k = 0; k < 6; k++) begin
            emit(ri12_inst(op6_mem, op4_ld_w, 5'(10 + k), 5'd0, offs[k]));
        end
        emit(ri12_inst(op6_mem, op4_ld_w, 5'd16, 5'd0, 12'(4 * rnd(256))));
        emit(ri12_inst(op6_base, op4_addi, 5'd20, 5'd0, 12'd5));
        emit(ri12_inst(op6_base, op4_addi, 5'd21, 5'd0, 12'd7));
        emit(br16_inst(op6_beq, 5'd21, 5'd20, 16'd2));   // not taken
        emit(mark);
        emit(br16_inst(op6_bne, 5'd21, 5'd20, 16'd2));   // taken
        emit(mark);
        emit(br16_inst(op6_beq, 5'd20, 5'd20, 16'd2));
        emit(mark);
        emit(br16_inst(op6_bne, 5'd20, 5'd20, 16'd2));
        emit(mark);
        emit(br26_inst(op6_b, 26'd2));
        emit(mark);
        // bl forward, jirl back through r1, then b over the jirl
        emit(br26_inst(op6_bl, 26'd3));
        emit(mark);
        emit(br26_inst(op6_b, 26'd3));
        emit(ri12_inst(op6_base, op4_addi, 5'd24, 5'd0, 12'd9));
        emit(br16_inst(op6_jirl, 5'd23, 5'd1, 16'd0));
        emit(rrr_inst(op5_add, 5'd25, 5'd23, 5'd0));
    endtask

    // architectural model, one instruction per call
    function automatic event_t ref_step();
        logic [31:0] w;
        logic [31:0] vj;
        logic [31:0] vk;
        logic [31:0] vd;
        logic [31:0] si12;
        logic [31:0] si16;
        logic [31:0] si26;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic [31:0] addr;
        logic        wr;
        event_t      ev;
        w = imem[ref_pc[9:2]];
        vj = ref_regs[w[9:5]];
        vk = ref_regs[w[14:10]];
        vd = ref_regs[w[4:0]];
        si12 = {{20{w[21]}}, w[21:10]};
        si16 = {{14{w[25]}}, w[25:10], 2'b00};
        si26 = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
        ev = '0;
        ev.pc = ref_pc;
        ev.num = w[4:0];
        next_pc = ref_pc + 4;
        res = '0;
        wr = 1'b1;
        case (w[31:26])
            op6_base: begin
                if (w[25:22] == op4_addi) begin
                    res = vj + si12;
                end else if (w[25:20] == {op4_reg, op2_reg}) begin
                    case (w[19:15])
                        op5_add:  res = vj + vk;
                        op5_sub:  res = vj - vk;
                        op5_slt:  res = {31'b0, $signed(vj) < $signed(vk)};
                        op5_sltu: res = {31'b0, vj < vk};
                        op5_nor:  res = ~(vj | vk);
                        op5_and:  res = vj & vk;
                        op5_or:   res = vj | vk;
                        op5_xor:  res = vj ^ vk;
                        default:  wr = 1'b0;
                    endcase
                end else begin
                    case (w[19:15])
                        op5_slli: res = vj << w[14:10];
                        op5_srli: res = vj >> w[14:10];
                        op5_srai: res = $unsigned($signed(vj) >>> w[14:10]);
                        default:  wr = 1'b0;
                    endcase
                end
            end
            op6_lu12i: res = {w[24:5], 12'b0};
            op6_mem: begin
                addr = vj + si12;
                if (w[25:22] == op4_ld_w) begin
                    res = ref_mem[addr[9:2]];
                end else begin
                    ref_mem[addr[9:2]] = vd;
                    ev.kind = 2'd2;
                    ev.addr = addr;
                    ev.data = vd;
                    wr = 1'b0;
                end
            end
            op6_jirl: begin
                res = ref_pc + 4;
                next_pc = vj + si16;
            end
            op6_bl: begin
                res = ref_pc + 4;
                ev.num = 5'd1;
                next_pc = ref_pc + si26;
            end
            op6_b: begin
                wr = 1'b0;
                next_pc = ref_pc + si26;
            end
            op6_beq: begin
                wr = 1'b0;
                if (vj == vd) begin
                    next_pc = ref_pc + si16;
                end
            end
            op6_bne: begin
                wr = 1'b0;
                if (vj != vd) begin
                    next_pc = ref_pc + si16;
                end
            end
            default: wr = 1'b0;
        endcase
        if (wr) begin
            ev.kind = 2'd1;
            ev.data = res;
            if (ev.num != 5'd0) begin
                ref_regs[ev.num] = res;
            end
        end
        ref_pc = next_pc;
        return ev;
    endfunction

    task automatic build_expected();
        event_t ev;
        for (int i = 0; i < 32; i++) begin
            ref_regs[5'(i)] = '0;
        end
        ref_pc = reset_pc;
        while (imem[ref_pc[9:2]] != br26_inst(op6_b, 26'd0) && n_steps < 1000) begin
            ev = ref_step();
            n_steps++;
            if (ev.kind != 2'd0) begin
                exp_q.push_back(ev);
            end
        end
        n_exp = exp_q.size();
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        err_value++;
    endtask

    task automatic check_write();
        event_t ev;
        if (seen >= n_exp) begin
            $display("%0t: register write to r%0d after the program ended", $time,
                     debug_wb_rf_wnum);
            err_other++;
        end else begin
            ev = exp_q[seen];
            if (ev.kind != 2'd1) begin
                $display("%0t: register write came where a store was expected", $time);
                err_other++;
            end
            if (debug_wb_rf_we != 4'b1111) begin
                value_error("debug_wb_rf_we", 32'(debug_wb_rf_we), 32'hf);
            end
            if (debug_wb_pc != ev.pc) begin
                value_error("debug_wb_pc", debug_wb_pc, ev.pc);
            end
            if (debug_wb_rf_wnum != ev.num) begin
                value_error("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum), 32'(ev.num));
            end
            if (debug_wb_rf_wdata != ev.data) begin
                value_error("debug_wb_rf_wdata", debug_wb_rf_wdata, ev.data);
            end
            seen++;
        end
    endtask

    task automatic check_store();
        event_t ev;
        if (seen >= n_exp) begin
            $display("%0t: store to %h after the program ended", $time, data_sram_addr);
            err_other++;
        end else begin
            ev = exp_q[seen];
            if (ev.kind != 2'd2) begin
                $display("%0t: store came where a register write was expected", $time);
                err_other++;
            end
            if (data_sram_addr != ev.addr) begin
                value_error("data_sram_addr", data_sram_addr, ev.addr);
            end
            if (data_sram_wdata != ev.data) begin
                value_error("data_sram_wdata", data_sram_wdata, ev.data);
            end
            seen++;
        end
    endtask

    // outputs settle after the rising edge, so compare on the falling one
    always @(negedge clk) begin
        if (!reset) begin
            if (debug_wb_rf_we != 4'b0000) begin
                check_write();
            end
            if (data_sram_we) begin
                check_store();
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d of %0d events seen, errors %0d + %0d",
                     cycles, seen, n_exp, err_value, err_other);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(30));
        reset = 1'b1;
        inst_sram_rdata = '0;
        data_sram_rdata = '0;
        for (int i = 0; i < 256; i++) begin
            dmem[8'(i)] = fill_word(32'(i * 4));
            ref_mem[8'(i)] = fill_word(32'(i * 4));
        end
        build_program();
        build_expected();
        cycle_limit = 8 + n_steps * 5 + 80;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (inst_sram_addr != reset_pc) begin
            value_error("inst_sram_addr", inst_sram_addr, reset_pc);
        end
        if (inst_sram_wdata != 32'd0) begin
            value_error("inst_sram_wdata", inst_sram_wdata, 32'd0);
        end
        if (inst_sram_we || data_sram_we || debug_wb_rf_we != 4'b0000) begin
            $display("%0t: a write strobe is high right after reset", $time);
            err_other++;
        end
        wait (seen >= n_exp);
        repeat (20) @(posedge clk);   // nothing more may retire
        $display("errors: %0d value, %0d other, %0d of %0d events checked",
                 err_value, err_other, seen, n_exp);
        if (err_value == 0 && err_other == 0 && seen == n_exp) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
